// ==== alu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none
module alu_exec (
  input  wire dx_pkg::word_t       rs_data,
  input  wire dx_pkg::word_t       rt_data,
  input  wire dx_pkg::word_t       imm,
  input  wire dx_pkg::word_t       pc,
  input  wire dx_pkg::opcode_t     opcode,
  input  wire dx_pkg::func_t       func,
  input  wire dx_pkg::result_sel_t result_sel,
  input  wire                      branch,
  input  wire                      save_pc,
  output dx_pkg::word_t            result,
  output logic                     branch_taken,
  output dx_pkg::word_t            branch_target
);
  import dx_pkg::*;

  word_t alu_out;
  word_t pc_plus2;

  assign pc_plus2 = pc + word_t'(2);

  // ********************
  // ALU
  // ********************
  always_comb begin
    case (opcode)
      OP_RTYPE: begin
        case (func)
          FUNC_ADD: alu_out = rs_data + rt_data;
          FUNC_SUB: alu_out = rs_data - rt_data;
          FUNC_XOR: alu_out = rs_data ^ rt_data;
          default:  alu_out = rs_data & rt_data; // FUNC_AND.
        endcase
      end
      OP_ADDI, OP_LD, OP_ST: alu_out = rs_data + imm; // Also the memory address.
      default:               alu_out = '0;
    endcase
  end

  always_comb begin
    case (result_sel)
      SEL_IMM: result = imm;
      SEL_PC2: result = pc_plus2; // Link value for JAL.
      default: result = alu_out;
    endcase
  end

  // JAL always redirects, BEQZ only on a zero rs.
  assign branch_taken  = save_pc || (branch && rs_data == '0);
  assign branch_target = pc_plus2 + imm;

endmodule
`default_nettype wire

// ==== decode_execute.sv ====
`timescale 1ns/1ps
`default_nettype none
module decode_execute (
  input  wire                   clk,
  input  wire                   reset,
  input  wire dx_pkg::word_t    instr,
  input  wire dx_pkg::word_t    pc,
  input  wire                   instr_valid,
  input  wire                   stall,
  input  wire                   wb_en,
  input  wire dx_pkg::reg_idx_t wb_rd,
  input  wire dx_pkg::word_t    wb_data,
  output dx_pkg::word_t         result,
  output dx_pkg::word_t         store_data,
  output dx_pkg::word_t         branch_target,
  output dx_pkg::reg_idx_t      rd,
  output logic                  reg_write,
  output logic                  mem_read,
  output logic                  mem_write,
  output logic                  mem_to_reg,
  output logic                  halt,
  output logic                  branch_taken,
  output logic                  nop
);
  import dx_pkg::*;

  // ********************
  // Decode stage
  // ********************
  logic        nop_d, reg_write_d, halt_d, mem_read_d, mem_write_d;
  logic        mem_to_reg_d, branch_d, save_pc_d;
  reg_idx_t    rs_d, rt_d, rd_d;
  word_t       imm_d, rs_data_d, rt_data_d;
  opcode_t     opcode_d;
  func_t       func_d;
  result_sel_t result_sel_d;

  // Execute stage
  word_t       rs_data_x, imm_x, pc_x;
  opcode_t     opcode_x;
  func_t       func_x;
  result_sel_t result_sel_x;
  logic        branch_x, save_pc_x;

  instr_decoder u_instr_decoder (
    .instr(instr), .instr_valid(instr_valid), .nop_d(nop_d),
    .rs(rs_d), .rt(rt_d), .rd(rd_d), .imm(imm_d), .opcode(opcode_d), .func(func_d),
    .result_sel(result_sel_d), .reg_write(reg_write_d), .halt(halt_d),
    .mem_read(mem_read_d), .mem_write(mem_write_d), .mem_to_reg(mem_to_reg_d),
    .branch(branch_d), .save_pc(save_pc_d)
  );

  reg_file u_reg_file (
    .clk(clk), .reset(reset), .rs(rs_d), .rt(rt_d), .rs_data(rs_data_d), .rt_data(rt_data_d),
    .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
  );

  id_ex u_id_ex (
    .clk(clk), .reset(reset), .stall(stall), .nop_d(nop_d), .nop_x(nop),
    .rs_data_d(rs_data_d), .rs_data_x(rs_data_x), .rt_data_d(rt_data_d), .rt_data_x(store_data),
    .imm_d(imm_d), .imm_x(imm_x), .pc_d(pc), .pc_x(pc_x), .rd_d(rd_d), .rd_x(rd),
    .opcode_d(opcode_d), .opcode_x(opcode_x), .func_d(func_d), .func_x(func_x),
    .result_sel_d(result_sel_d), .result_sel_x(result_sel_x),
    .reg_write_d(reg_write_d), .reg_write_x(reg_write), .halt_d(halt_d), .halt_x(halt),
    .mem_read_d(mem_read_d), .mem_read_x(mem_read), .mem_write_d(mem_write_d),
    .mem_write_x(mem_write), .mem_to_reg_d(mem_to_reg_d), .mem_to_reg_x(mem_to_reg),
    .branch_d(branch_d), .branch_x(branch_x), .save_pc_d(save_pc_d), .save_pc_x(save_pc_x)
  );

  alu_exec u_alu_exec (
    .rs_data(rs_data_x), .rt_data(store_data), .imm(imm_x), .pc(pc_x), .opcode(opcode_x),
    .func(func_x), .result_sel(result_sel_x), .branch(branch_x), .save_pc(save_pc_x),
    .result(result), .branch_taken(branch_taken), .branch_target(branch_target)
  );

endmodule
`default_nettype wire

// ==== dx_pkg.sv ====
`default_nettype none
package dx_pkg;

  // ********************
  // Widths and types
  // ********************
  localparam int WORD_W   = 16;
  localparam int NUM_REGS = 8;

  // Instruction field positions.
  localparam int OP_MSB   = 15;
  localparam int OP_LSB   = 11;
  localparam int RS_MSB   = 10;
  localparam int RS_LSB   = 8;
  localparam int RT_MSB   = 7;
  localparam int RT_LSB   = 5;
  localparam int RD_MSB   = 4;
  localparam int RD_LSB   = 2;
  localparam int FUNC_MSB = 1;
  localparam int FUNC_LSB = 0;
  localparam int IMM5_W   = 5;
  localparam int IMM8_W   = 8;
  localparam int IMM11_W  = 11;

  typedef logic [WORD_W-1:0]           word_t;       // Data word, PC or immediate.
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
  typedef logic [OP_MSB-OP_LSB:0]      opcode_t;
  typedef logic [FUNC_MSB-FUNC_LSB:0]  func_t;
  typedef logic [1:0]                  result_sel_t;

  localparam reg_idx_t LINK_REG = 3'd7; // JAL writes its return address here.

  // ********************
  // Encodings
  // ********************
  localparam opcode_t OP_HALT  = 5'b00000;
  localparam opcode_t OP_NOP   = 5'b00001;
  localparam opcode_t OP_JAL   = 5'b00110;
  localparam opcode_t OP_ADDI  = 5'b01000;
  localparam opcode_t OP_BEQZ  = 5'b01100;
  localparam opcode_t OP_ST    = 5'b10000;
  localparam opcode_t OP_LD    = 5'b10001;
  localparam opcode_t OP_LBI   = 5'b11000;
  localparam opcode_t OP_RTYPE = 5'b11011;

  localparam func_t FUNC_ADD = 2'd0;
  localparam func_t FUNC_SUB = 2'd1; // rs minus rt.
  localparam func_t FUNC_XOR = 2'd2;
  localparam func_t FUNC_AND = 2'd3;

  localparam result_sel_t SEL_ALU = 2'd0;
  localparam result_sel_t SEL_IMM = 2'd1;
  localparam result_sel_t SEL_PC2 = 2'd2;

endpackage
`default_nettype wire

// ==== id_ex.sv ====
`timescale 1ns/1ps
`default_nettype none
module id_ex (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      stall,
  input  wire                      nop_d,
  output logic                     nop_x,
  input  wire dx_pkg::word_t       rs_data_d,
  output dx_pkg::word_t            rs_data_x,
  input  wire dx_pkg::word_t       rt_data_d,
  output dx_pkg::word_t            rt_data_x,
  input  wire dx_pkg::word_t       imm_d,
  output dx_pkg::word_t            imm_x,
  input  wire dx_pkg::word_t       pc_d,
  output dx_pkg::word_t            pc_x,
  input  wire dx_pkg::reg_idx_t    rd_d,
  output dx_pkg::reg_idx_t         rd_x,
  input  wire dx_pkg::opcode_t     opcode_d,
  output dx_pkg::opcode_t          opcode_x,
  input  wire dx_pkg::func_t       func_d,
  output dx_pkg::func_t            func_x,
  input  wire dx_pkg::result_sel_t result_sel_d,
  output dx_pkg::result_sel_t      result_sel_x,
  input  wire                      reg_write_d,
  output logic                     reg_write_x,
  input  wire                      halt_d,
  output logic                     halt_x,
  input  wire                      mem_read_d,
  output logic                     mem_read_x,
  input  wire                      mem_write_d,
  output logic                     mem_write_x,
  input  wire                      mem_to_reg_d,
  output logic                     mem_to_reg_x,
  input  wire                      branch_d,
  output logic                     branch_x,
  input  wire                      save_pc_d,
  output logic                     save_pc_x
);
  import dx_pkg::*;

  logic        keep; // Payload holds on a stall and on a bubble.
  word_t       rs_data_n, rt_data_n, imm_n, pc_n;
  reg_idx_t    rd_n;
  opcode_t     opcode_n;
  func_t       func_n;
  result_sel_t result_sel_n;
  logic        reg_write_n, halt_n, mem_read_n, mem_write_n;
  logic        mem_to_reg_n, branch_n, save_pc_n, nop_n;

  assign keep = stall || nop_d;

  // ********************
  // Hold multiplexers
  // ********************
  // Only pc, reg_write, halt and nop load on a bubble.
  assign pc_n         = stall ? pc_x        : pc_d;
  assign reg_write_n  = stall ? reg_write_x : reg_write_d;
  assign halt_n       = stall ? halt_x      : halt_d;
  assign nop_n        = stall ? nop_x       : nop_d;
  assign rs_data_n    = keep ? rs_data_x    : rs_data_d;
  assign rt_data_n    = keep ? rt_data_x    : rt_data_d;
  assign imm_n        = keep ? imm_x        : imm_d;
  assign rd_n         = keep ? rd_x         : rd_d;
  assign opcode_n     = keep ? opcode_x     : opcode_d;
  assign func_n       = keep ? func_x       : func_d;
  assign result_sel_n = keep ? result_sel_x : result_sel_d;
  assign mem_read_n   = keep ? mem_read_x   : mem_read_d;
  assign mem_write_n  = keep ? mem_write_x  : mem_write_d;
  assign mem_to_reg_n = keep ? mem_to_reg_x : mem_to_reg_d;
  assign branch_n     = keep ? branch_x     : branch_d;
  assign save_pc_n    = keep ? save_pc_x    : save_pc_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      {rs_data_x, rt_data_x, imm_x, pc_x} <= '0;
      {rd_x, opcode_x, func_x, result_sel_x} <= '0;
      {reg_write_x, halt_x, mem_read_x, mem_write_x} <= '0;
      {mem_to_reg_x, branch_x, save_pc_x, nop_x} <= '0;
    end else begin
      {rs_data_x, rt_data_x, imm_x, pc_x} <= {rs_data_n, rt_data_n, imm_n, pc_n};
      {rd_x, opcode_x, func_x, result_sel_x} <= {rd_n, opcode_n, func_n, result_sel_n};
      {reg_write_x, halt_x, mem_read_x, mem_write_x} <=
        {reg_write_n, halt_n, mem_read_n, mem_write_n};
      {mem_to_reg_x, branch_x, save_pc_x, nop_x} <= {mem_to_reg_n, branch_n, save_pc_n, nop_n};
    end
  end

  assert property (@(posedge clk) (stall && !reset) |=>
    $stable({rs_data_x, rt_data_x, imm_x, pc_x, rd_x, opcode_x, func_x, result_sel_x,
             reg_write_x, halt_x, mem_read_x, mem_write_x, mem_to_reg_x, branch_x,
             save_pc_x, nop_x}))
    else $error("id_ex outputs changed under stall.");

endmodule
`default_nettype wire

// ==== instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
module instr_decoder (
  input  wire dx_pkg::word_t instr,
  input  wire                instr_valid,
  output logic               nop_d,
  output dx_pkg::reg_idx_t   rs,
  output dx_pkg::reg_idx_t   rt,
  output dx_pkg::reg_idx_t   rd,
  output dx_pkg::word_t      imm,
  output dx_pkg::opcode_t    opcode,
  output dx_pkg::func_t      func,
  output dx_pkg::result_sel_t result_sel,
  output logic               reg_write,
  output logic               halt,
  output logic               mem_read,
  output logic               mem_write,
  output logic               mem_to_reg,
  output logic               branch,
  output logic               save_pc
);
  import dx_pkg::*;

  word_t    imm5;
  word_t    imm8;
  word_t    imm11;
  reg_idx_t rd_rtype;
  logic     legal;
  logic     reg_write_raw;
  logic     halt_raw;
  logic     mem_read_raw;
  logic     mem_write_raw;
  logic     mem_to_reg_raw;
  logic     branch_raw;
  logic     save_pc_raw;

  assign opcode   = instr[OP_MSB:OP_LSB];
  assign rs       = instr[RS_MSB:RS_LSB];
  assign rt       = instr[RT_MSB:RT_LSB];
  assign rd_rtype = instr[RD_MSB:RD_LSB];
  assign func     = instr[FUNC_MSB:FUNC_LSB];

  assign imm5  = {{(WORD_W-IMM5_W){instr[IMM5_W-1]}}, instr[IMM5_W-1:0]};
  assign imm8  = {{(WORD_W-IMM8_W){instr[IMM8_W-1]}}, instr[IMM8_W-1:0]};
  assign imm11 = {{(WORD_W-IMM11_W){instr[IMM11_W-1]}}, instr[IMM11_W-1:0]};

  always_comb begin
    legal          = 1'b1;
    rd             = rt;     // ADDI and LD write rt.
    imm            = imm5;
    result_sel     = SEL_ALU;
    reg_write_raw  = 1'b0;
    halt_raw       = 1'b0;
    mem_read_raw   = 1'b0;
    mem_write_raw  = 1'b0;
    mem_to_reg_raw = 1'b0;
    branch_raw     = 1'b0;
    save_pc_raw    = 1'b0;
    case (opcode)
      OP_HALT:  halt_raw = 1'b1;
      OP_JAL: begin
        rd            = LINK_REG;
        imm           = imm11;
        result_sel    = SEL_PC2;
        reg_write_raw = 1'b1;
        save_pc_raw   = 1'b1;
      end
      OP_ADDI:  reg_write_raw = 1'b1;
      OP_BEQZ: begin
        imm        = imm8;
        branch_raw = 1'b1;
      end
      OP_ST:    mem_write_raw = 1'b1; // Address is rs plus imm5.
      OP_LD: begin
        mem_read_raw   = 1'b1;
        mem_to_reg_raw = 1'b1;
        reg_write_raw  = 1'b1;
      end
      OP_LBI: begin
        rd            = rs;
        imm           = imm8;
        result_sel    = SEL_IMM;
        reg_write_raw = 1'b1;
      end
      OP_RTYPE: begin
        rd            = rd_rtype;
        reg_write_raw = 1'b1;
      end
      default:  legal = 1'b0; // NOP and unknown opcodes become bubbles.
    endcase
  end

  // A bubble carries no side effects into execute.
  assign nop_d      = !instr_valid || !legal;
  assign reg_write  = reg_write_raw && !nop_d;
  assign halt       = halt_raw && !nop_d;
  assign mem_read   = mem_read_raw && !nop_d;
  assign mem_write  = mem_write_raw && !nop_d;
  assign mem_to_reg = mem_to_reg_raw && !nop_d;
  assign branch     = branch_raw && !nop_d;
  assign save_pc    = save_pc_raw && !nop_d;

  always_comb begin
    assert (!(mem_read && mem_write)) else $error("Load and store decoded together.");
  end

endmodule
`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none
module reg_file (
  input  wire                   clk,
  input  wire                   reset,
  input  wire dx_pkg::reg_idx_t rs,
  input  wire dx_pkg::reg_idx_t rt,
  output dx_pkg::word_t         rs_data,
  output dx_pkg::word_t         rt_data,
  input  wire                   wb_en,
  input  wire dx_pkg::reg_idx_t wb_rd,
  input  wire dx_pkg::word_t    wb_data
);
  import dx_pkg::*;

  word_t regs [NUM_REGS];

  // ********************
  // Write port
  // ********************
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Same-cycle writeback bypasses the array so decode sees the new value.
  assign rs_data = (wb_en && wb_rd == rs) ? wb_data : regs[rs];
  assign rt_data = (wb_en && wb_rd == rt) ? wb_data : regs[rt];

  assert property (@(posedge clk) disable iff (reset) wb_en |-> !$isunknown(wb_rd))
    else $error("Writeback index unknown while wb_en is high.");

endmodule
`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the decode/execute testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_decode_execute -f tb.f -o sim_decode_execute
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

./obj_dir/sim_decode_execute > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

if grep -qxF "Done: no errors" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// ==== tb.f ====
dx_pkg.sv
instr_decoder.sv
reg_file.sv
id_ex.sv
alu_exec.sv
decode_execute.sv
tb_decode_execute.sv

// ==== tb_decode_execute.sv ====
`timescale 1ns/1ps
`default_nettype none
module tb_decode_execute;
  import dx_pkg::*;

  localparam int MAX_CYCLES = 2000; // The directed tests below need about 75 cycles.

  logic     clk = 1'b0;
  logic     reset;
  word_t    instr, pc, wb_data;
  logic     instr_valid, stall, wb_en;
  reg_idx_t wb_rd;
  word_t    result, store_data, branch_target;
  reg_idx_t rd;
  logic     reg_write, mem_read, mem_write, mem_to_reg, halt, branch_taken, nop;

  word_t model_regs [NUM_REGS]; // Register contents as the testbench expects them.
  int    errors = 0;
  int    checks = 0;
  int    cycles = 0;

  decode_execute u_decode_execute (
    .clk(clk), .reset(reset), .instr(instr), .pc(pc), .instr_valid(instr_valid),
    .stall(stall), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
    .result(result), .store_data(store_data), .branch_target(branch_target), .rd(rd),
    .reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write),
    .mem_to_reg(mem_to_reg), .halt(halt), .branch_taken(branch_taken), .nop(nop)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles.", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  // ********************
  // Helpers
  // ********************
  task automatic next_cycle();
    @(posedge clk);
    #1; // Inputs change 1 ns after the edge.
  endtask

  function automatic word_t random_word();
    return word_t'($urandom());
  endfunction

  task automatic check_word(input string what, input word_t expected, input word_t actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("[ERROR] t=%0t %s: expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("[ERROR] t=%0t %s: expected %b, got %b", $time, what, expected, actual);
    end
  endtask

  task automatic check_controls(input logic exp_rw, input logic exp_rd_mem,
                                input logic exp_wr_mem, input logic exp_m2r,
                                input logic exp_halt, input logic exp_taken,
                                input logic exp_nop);
    check_bit("reg_write", exp_rw, reg_write);
    check_bit("mem_read", exp_rd_mem, mem_read);
    check_bit("mem_write", exp_wr_mem, mem_write);
    check_bit("mem_to_reg", exp_m2r, mem_to_reg);
    check_bit("halt", exp_halt, halt);
    check_bit("branch_taken", exp_taken, branch_taken);
    check_bit("nop", exp_nop, nop);
  endtask

  task automatic write_reg(input reg_idx_t idx, input word_t value);
    wb_en   = 1'b1;
    wb_rd   = idx;
    wb_data = value;
    next_cycle();
    wb_en = 1'b0;
    model_regs[idx] = value;
  endtask

  // One valid instruction, then the decode input goes idle.
  task automatic issue(input word_t ins, input word_t at_pc);
    instr       = ins;
    pc          = at_pc;
    instr_valid = 1'b1;
    next_cycle();
    instr_valid = 1'b0;
  endtask

  // ********************
  // Tests
  // ********************
  task automatic test_rtype(input func_t f);
    reg_idx_t rs_i, rt_i, rd_i;
    word_t    a, b, expected;
    rs_i = reg_idx_t'($urandom_range(7, 0));
    rt_i = rs_i + 3'd1;
    rd_i = reg_idx_t'($urandom_range(7, 0));
    write_reg(rs_i, random_word());
    write_reg(rt_i, random_word());
    a = model_regs[rs_i];
    b = model_regs[rt_i];
    case (f)
      FUNC_ADD: expected = a + b;
      FUNC_SUB: expected = a - b;
      FUNC_XOR: expected = a ^ b;
      default:  expected = a & b;
    endcase
    issue({OP_RTYPE, rs_i, rt_i, rd_i, f}, random_word());
    check_word("rtype result", expected, result);
    check_word("rtype rd", word_t'(rd_i), word_t'(rd));
    check_word("rtype store_data", b, store_data);
    check_controls(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  // ADDI, LD and ST use rt and imm5, LBI reads the same bits as imm8.
  task automatic test_imm(input opcode_t op);
    reg_idx_t   rs_i, rt_i;
    logic [7:0] imm8;
    word_t      imm_ext, expected;
    rs_i = reg_idx_t'($urandom_range(7, 0));
    rt_i = rs_i + 3'd2;
    imm8 = {rt_i, 5'($urandom())};
    write_reg(rs_i, random_word());
    write_reg(rt_i, random_word());
    if (op == OP_LBI) begin
      imm_ext  = {{8{imm8[7]}}, imm8};
      expected = imm_ext;
    end else begin
      imm_ext  = {{11{imm8[4]}}, imm8[4:0]};
      expected = model_regs[rs_i] + imm_ext;
    end
    issue({op, rs_i, imm8}, random_word());
    check_word("imm result", expected, result);
    check_word("imm store_data", model_regs[rt_i], store_data);
    if (op != OP_ST) begin
      check_word("imm rd", word_t'((op == OP_LBI) ? rs_i : rt_i), word_t'(rd));
    end
    check_controls(op != OP_ST, op == OP_LD, op == OP_ST, op == OP_LD, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic test_beqz(input logic rs_zero);
    reg_idx_t   rs_i;
    logic [7:0] imm8;
    word_t      at_pc;
    rs_i  = reg_idx_t'($urandom_range(7, 0));
    imm8  = 8'($urandom());
    at_pc = random_word() & 16'hfffe;
    write_reg(rs_i, rs_zero ? 16'h0000 : (random_word() | 16'h0001));
    issue({OP_BEQZ, rs_i, imm8}, at_pc);
    check_word("beqz target", at_pc + 16'd2 + {{8{imm8[7]}}, imm8}, branch_target);
    check_controls(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, rs_zero, 1'b0);
  endtask

  task automatic test_jal();
    logic [10:0] imm11;
    word_t       at_pc;
    imm11 = 11'($urandom());
    at_pc = random_word() & 16'hfffe;
    issue({OP_JAL, imm11}, at_pc);
    check_word("jal link value", at_pc + 16'd2, result);
    check_word("jal rd", 16'd7, word_t'(rd));
    check_word("jal target", at_pc + 16'd2 + {{5{imm11[10]}}, imm11}, branch_target);
    check_controls(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
  endtask

  task automatic test_stall();
    word_t expected;
    write_reg(3'd1, random_word());
    write_reg(3'd2, random_word());
    expected = model_regs[1] + model_regs[2];
    issue({OP_RTYPE, 3'd1, 3'd2, 3'd5, FUNC_ADD}, 16'h0100);
    check_word("result before stall", expected, result);
    stall = 1'b1;
    for (int i = 0; i < 4; i++) begin
      instr       = {OP_LD, 3'(i), 3'd3, 5'd4}; // A new load waits in decode.
      instr_valid = 1'b1;
      pc          = pc + 16'd2;
      next_cycle();
      check_word("result under stall", expected, result);
      check_word("rd under stall", 16'd5, word_t'(rd));
      check_word("store_data under stall", model_regs[2], store_data);
      check_controls(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    stall       = 1'b0;
    instr_valid = 1'b0;
  endtask

  task automatic test_bubble();
    word_t expected;
    write_reg(3'd3, random_word());
    expected = model_regs[3] + 16'h0005;
    issue({OP_ADDI, 3'd3, 3'd4, 5'd5}, 16'h0200);
    check_word("addi before bubble", expected, result);
    instr       = {OP_NOP, 11'h7ff};
    instr_valid = 1'b1;
    next_cycle();
    instr_valid = 1'b0;
    check_word("result across bubble", expected, result);
    check_controls(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    issue({OP_HALT, 11'd0}, 16'h0204);
    check_controls(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    next_cycle(); // Idle decode clears halt.
    check_controls(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
  endtask

  task automatic test_bypass();
    word_t fresh;
    fresh = random_word();
    write_reg(3'd6, ~fresh);
    write_reg(3'd0, random_word());
    instr       = {OP_RTYPE, 3'd6, 3'd0, 3'd2, FUNC_XOR};
    pc          = 16'h0300;
    instr_valid = 1'b1;
    wb_en       = 1'b1;
    wb_rd       = 3'd6;
    wb_data     = fresh;
    next_cycle();
    wb_en       = 1'b0;
    instr_valid = 1'b0;
    model_regs[6] = fresh;
    check_word("bypass result", fresh ^ model_regs[0], result);
  endtask

  initial begin
    void'($urandom(32'h641737f1));
    reset       = 1'b1;
    instr       = '0;
    pc          = '0;
    instr_valid = 1'b0;
    stall       = 1'b0;
    wb_en       = 1'b0;
    wb_rd       = '0;
    wb_data     = '0;
    foreach (model_regs[i]) model_regs[i] = '0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    check_controls(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    for (int n = 0; n < 3; n++) begin
      for (int f = 0; f < 4; f++) test_rtype(func_t'(f));
    end
    test_imm(OP_ADDI);
    test_imm(OP_LBI);
    test_imm(OP_LD);
    test_imm(OP_ST);
    test_beqz(1'b1);
    test_beqz(1'b0);
    test_jal();
    test_stall();
    test_bubble();
    test_bypass();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
`default_nettype wire
